//--- cpu_pkg.sv
package cpu_pkg;

    // ========================================================================
    // ISA widths and reset state
    // ========================================================================
    localparam int xlen = 32;
    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;
    localparam logic [xlen-1:0] pc_step = 32'd4;        // One 32-bit word per instruction

    // Opcodes and function fields
    localparam logic [6:0] op_jal = 7'b110_1111;
    localparam logic [6:0] op_jalr = 7'b110_0111;
    localparam logic [6:0] op_op = 7'b011_0011;
    localparam logic [6:0] funct7_muldiv = 7'b000_0001; // M extension marker
    localparam logic [2:0] funct3_jalr = 3'd0;
    localparam logic [2:0] funct3_mul = 3'd0;
    localparam logic [2:0] funct3_div = 3'd4;

    // Mul/div execution latencies in cycles
    localparam int mul_cycles = 3;
    localparam int div_cycles = 6;
    localparam int md_cnt_w = $clog2(div_cycles);

    // ========================================================================
    // FSM encodings used by pc_gen
    // ========================================================================
    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_en = 2'd1;                // Address accepted, data pending
    localparam logic [1:0] st_fn = 2'd2;                // Word delivered to decode

    localparam logic [1:0] md_idle = 2'd0;
    localparam logic [1:0] md_arth = 2'd1;              // Unit busy
    localparam logic [1:0] md_af = 2'd2;                // Done, read still open
    localparam logic [1:0] md_tend = 2'd3;

    // One instruction word, seen as R-type or I-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } instr_word_u;

endpackage

//--- bus_pkg.sv
package bus_pkg;

    // ========================================================================
    // Fetch bus widths
    // ========================================================================
    localparam int addr_w = 32;
    localparam int data_w = 32;

    // Response timing bounds of the instruction memory
    localparam int ready_delay_max = 3;     // Cycles ar_ready may stay low
    localparam int r_latency_min = 1;       // r_valid at least this long after ar_hs
    localparam int r_latency_max = 4;

    // Only one read may be open on the bus
    localparam int max_outstanding = 1;

endpackage

//--- pc_gen.sv
`timescale 1ns/10ps

module pc_gen
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            ar_hs,
    input  logic            r_done,
    input  logic            redirect,
    input  logic            jalr_hold,
    input  logic [xlen-1:0] next_pc,
    input  logic            is_mul,
    input  logic            is_div,
    input  logic            mul_done,
    input  logic            div_done,
    input  logic            hold,
    output logic [xlen-1:0] curr_pc,
    output logic            fetch_req
);

    logic [1:0] fetch_state;
    logic [1:0] fetch_next;
    logic [1:0] md_state;
    logic [1:0] md_next;
    logic       jalr_delay;
    logic       may_fetch;

    // No new fetch while stalled, while mul/div runs or while a jump is open
    assign may_fetch = !hold && (md_state == md_idle) && !is_mul && !is_div &&
                       !redirect && !jalr_hold && !jalr_delay;

    // ========================================================================
    // Fetch phase FSM
    // ========================================================================
    always_comb begin
        case (fetch_state)
            st_idle: fetch_next = ar_hs ? st_en : st_idle;
            st_en:   fetch_next = r_done ? st_fn : st_en;
            st_fn:   fetch_next = st_idle;
            default: fetch_next = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_state <= st_idle;
            fetch_req <= 1'b0;
            jalr_delay <= 1'b0;
        end else begin
            fetch_state <= fetch_next;
            fetch_req <= (fetch_state == st_idle) && !ar_hs && may_fetch;
            jalr_delay <= jalr_hold;                // Target load one cycle after the hold
        end
    end

    // ========================================================================
    // Mul/div hold FSM
    // ========================================================================
    always_comb begin
        case (md_state)
            md_idle: md_next = (is_mul || is_div) ? md_arth : md_idle;
            md_arth: begin
                if (mul_done || div_done)
                    md_next = (fetch_state == st_idle) ? md_tend : md_af;
                else
                    md_next = md_arth;
            end
            md_af:   md_next = (fetch_state == st_idle) ? md_tend : md_af;
            md_tend: md_next = md_idle;
            default: md_next = md_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            md_state <= md_idle;
        else
            md_state <= md_next;
    end

    // ========================================================================
    // Program counter
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= reset_pc;
        end else if (md_state == md_tend) begin
            curr_pc <= curr_pc + pc_step;           // Deferred step of the mul/div
        end else if (is_mul || is_div || md_state != md_idle) begin
            curr_pc <= curr_pc;
        end else if (jalr_hold) begin
            curr_pc <= curr_pc;
        end else if (jalr_delay) begin
            curr_pc <= next_pc;
        end else if (redirect) begin
            curr_pc <= next_pc;
        end else if (fetch_state == st_fn) begin
            curr_pc <= curr_pc + pc_step;
        end
    end

    // Decode raises at most one kind of jump per word
    a_one_jump: assert property (@(posedge clk) disable iff (!rst_n)
        !(redirect && jalr_hold));

endmodule

//--- fetch_port.sv
`timescale 1ns/10ps

module fetch_port
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_req,
    input  logic [addr_w-1:0] curr_pc,
    input  logic              ar_ready,
    input  logic              r_valid,
    input  logic [data_w-1:0] r_data,
    output logic              ar_valid,
    output logic [addr_w-1:0] ar_addr,
    output logic              ar_hs,
    output logic              r_done,
    output logic [data_w-1:0] instr
);

    logic rd_pend;                                  // Address accepted, waiting for data
    logic start;
    logic rd_ret;

    assign ar_hs = ar_valid && ar_ready;
    assign start = fetch_req && !ar_valid && !rd_pend;
    assign rd_ret = rd_pend && r_valid;

    // ========================================================================
    // Address phase and read tracking
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
            rd_pend <= 1'b0;
            r_done <= 1'b0;
        end else begin
            r_done <= rd_ret;                       // Pulses together with the new word
            if (ar_hs) begin
                ar_valid <= 1'b0;
                rd_pend <= 1'b1;
            end else if (start) begin
                ar_valid <= 1'b1;
            end
            if (rd_ret)
                rd_pend <= 1'b0;
        end
    end

    // Address and data words
    always_ff @(posedge clk) begin
        if (start)
            ar_addr <= curr_pc;
        if (rd_ret)
            instr <= r_data;
    end

    // A stalled request keeps its address on the bus
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)));

    // Data only returns for an accepted address
    a_no_stray_data: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid |-> rd_pend);

endmodule

//--- instr_decode.sv
`timescale 1ns/10ps

module instr_decode
    import cpu_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic            r_done,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] curr_pc,
    output logic            redirect,
    output logic            jalr_hold,
    output logic [xlen-1:0] next_pc,
    output logic            is_mul,
    output logic            is_div,
    output logic            commit_valid,
    output logic [xlen-1:0] commit_pc,
    output logic [xlen-1:0] commit_instr
);

    instr_word_u     word;
    logic            jal_hit;
    logic            jalr_hit;
    logic            mul_hit;
    logic            div_hit;
    logic            muldiv;
    logic [xlen-1:0] jal_imm;
    logic [xlen-1:0] jalr_imm;
    logic [xlen-1:0] target;

    assign word = instr;

    // ========================================================================
    // Classification
    // ========================================================================
    assign muldiv = (word.r.opcode == op_op) && (word.r.funct7 == funct7_muldiv);
    assign mul_hit = muldiv && (word.r.funct3 == funct3_mul);
    assign div_hit = muldiv && (word.r.funct3 == funct3_div);
    assign jal_hit = (instr[6:0] == op_jal);

    // Only x0 is supported as the jalr base
    assign jalr_hit = (word.i.opcode == op_jalr) && (word.i.funct3 == funct3_jalr) &&
                      (word.i.rs1 == 5'd0);

    // Jump targets
    assign jal_imm = {{(xlen-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                      instr[30:21], 1'b0};
    assign jalr_imm = {{(xlen-12){word.i.imm[11]}}, word.i.imm};

    always_comb begin
        if (jal_hit)
            target = curr_pc + jal_imm;
        else
            target = jalr_imm & ~xlen'(1);          // Base register is zero
    end

    // ========================================================================
    // Commit and control pulses
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            commit_valid <= 1'b0;
            redirect <= 1'b0;
            jalr_hold <= 1'b0;
            is_mul <= 1'b0;
            is_div <= 1'b0;
        end else begin
            commit_valid <= r_done;
            redirect <= r_done && jal_hit;
            jalr_hold <= r_done && jalr_hit;
            is_mul <= r_done && mul_hit;
            is_div <= r_done && div_hit;
        end
    end

    // next_pc stays put until the next jump so the delayed jalr load sees it
    always_ff @(posedge clk) begin
        if (r_done) begin
            commit_pc <= curr_pc;
            commit_instr <= instr;
        end
        if (r_done && (jal_hit || jalr_hit))
            next_pc <= target;
    end

endmodule

//--- md_latency_timer.sv
`timescale 1ns/10ps

module md_latency_timer
    import cpu_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic is_mul,
    input  logic is_div,
    output logic mul_done,
    output logic div_done,
    output logic busy
);

    logic [md_cnt_w-1:0] cnt;       // Remaining cycles after this one
    logic                kind_div;
    logic                last;

    assign last = busy && (cnt == '0);
    assign mul_done = last && !kind_div;
    assign div_done = last && kind_div;

    // ========================================================================
    // Latency counter
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            cnt <= '0;
            kind_div <= 1'b0;
        end else if (is_mul || is_div) begin
            busy <= 1'b1;
            kind_div <= is_div;
            if (is_div)
                cnt <= md_cnt_w'(div_cycles - 1);
            else
                cnt <= md_cnt_w'(mul_cycles - 1);
        end else if (busy) begin
            if (last)
                busy <= 1'b0;
            else
                cnt <= cnt - 1'b1;
        end
    end

    // Front end must wait for the unit before starting another op
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        (is_mul || is_div) |-> !busy);

    a_mul_latency: assert property (@(posedge clk) disable iff (!rst_n)
        is_mul |-> ##mul_cycles mul_done);

    a_div_latency: assert property (@(posedge clk) disable iff (!rst_n)
        is_div |-> ##div_cycles div_done);

endmodule

//--- fetch_frontend_top.sv
`timescale 1ns/10ps

module fetch_frontend_top
    import cpu_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hold,
    input  logic              ar_ready,
    input  logic              r_valid,
    input  logic [data_w-1:0] r_data,
    output logic              ar_valid,
    output logic [addr_w-1:0] ar_addr,
    output logic              commit_valid,
    output logic [xlen-1:0]   commit_pc,
    output logic [xlen-1:0]   commit_instr,
    output logic              md_busy
);

    logic            ar_hs;
    logic            r_done;
    logic            fetch_req;
    logic [xlen-1:0] curr_pc;
    logic [xlen-1:0] instr;
    logic            redirect;
    logic            jalr_hold;
    logic [xlen-1:0] next_pc;
    logic            is_mul;
    logic            is_div;
    logic            mul_done;
    logic            div_done;

    pc_gen u_pc_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar_hs     (ar_hs),
        .r_done    (r_done),
        .redirect  (redirect),
        .jalr_hold (jalr_hold),
        .next_pc   (next_pc),
        .is_mul    (is_mul),
        .is_div    (is_div),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .hold      (hold),
        .curr_pc   (curr_pc),
        .fetch_req (fetch_req)
    );

    fetch_port u_fetch_port (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .curr_pc   (curr_pc),
        .ar_ready  (ar_ready),
        .r_valid   (r_valid),
        .r_data    (r_data),
        .ar_valid  (ar_valid),
        .ar_addr   (ar_addr),
        .ar_hs     (ar_hs),
        .r_done    (r_done),
        .instr     (instr)
    );

    instr_decode u_instr_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .r_done       (r_done),
        .instr        (instr),
        .curr_pc      (curr_pc),
        .redirect     (redirect),
        .jalr_hold    (jalr_hold),
        .next_pc      (next_pc),
        .is_mul       (is_mul),
        .is_div       (is_div),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_instr (commit_instr)
    );

    md_latency_timer u_md_latency_timer (
        .clk      (clk),
        .rst_n    (rst_n),
        .is_mul   (is_mul),
        .is_div   (is_div),
        .mul_done (mul_done),
        .div_done (div_done),
        .busy     (md_busy)
    );

endmodule

//--- tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

    // ========================================================================
    // Program image
    // ========================================================================
    localparam logic [xlen-1:0] region_b = 32'hFFFF_F800;  // jalr target below zero
    localparam logic [xlen-1:0] region_c = 32'h0000_0104;

    // OP-IMM fillers keyed on the whole address
    function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] addr);
        return {addr[31:7] ^ addr[24:0], 7'b001_0011};
    endfunction

    function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
        if (prog_words.exists(addr))
            return prog_words[addr];
        return fill_word(addr);
    endfunction

    function automatic logic [xlen-1:0] enc_muldiv(input logic [2:0] f3);
        instr_word_u w;
        w.r.funct7 = funct7_muldiv;
        w.r.rs2 = 5'd2;
        w.r.rs1 = 5'd1;
        w.r.funct3 = f3;
        w.r.rd = 5'd3;
        w.r.opcode = op_op;
        return w;
    endfunction

    function automatic logic [xlen-1:0] enc_jalr(input logic [11:0] imm);
        instr_word_u w;
        w.i.imm = imm;
        w.i.rs1 = 5'd0;
        w.i.funct3 = 3'd0;
        w.i.rd = 5'd1;
        w.i.opcode = op_jalr;
        return w;
    endfunction

    function automatic logic [xlen-1:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, op_jal};
    endfunction

    task automatic build_program();
        prog_words[reset_pc + 32'h08] = enc_muldiv(3'd0);
        prog_words[reset_pc + 32'h10] = enc_muldiv(3'd4);
        prog_words[reset_pc + 32'h14] = enc_jal(21'd12);       // Skips two words
        prog_words[reset_pc + 32'h24] = enc_jalr(12'h801);     // Odd target rounds down
        prog_words[region_b + 32'h04] = enc_muldiv(3'd0);
        prog_words[region_b + 32'h08] = enc_jal(21'd16);
        prog_words[region_b + 32'h14] = enc_jalr(12'h104);
        prog_words[region_b + 32'h18] = enc_muldiv(3'd4);
        prog_words[region_b + 32'h1C] = enc_jal(21'h1F_FFF4);  // Backward by 12
        prog_words[region_c + 32'h08] = enc_muldiv(3'd0);
        prog_words[region_c + 32'h14] = enc_muldiv(3'd4);
        prog_words[region_c + 32'h1C] = enc_jal(21'd8);
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================
    function automatic logic [xlen-1:0] ref_next_pc(input logic [xlen-1:0] pc,
                                                    input logic [xlen-1:0] word);
        instr_word_u     w;
        logic [xlen-1:0] imm;
        w = word;
        if (w.r.opcode == op_jal) begin
            imm = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            return pc + imm;
        end
        if (w.i.opcode == op_jalr && w.i.rs1 == 5'd0) begin
            imm = {{20{w.i.imm[11]}}, w.i.imm};
            return {imm[xlen-1:1], 1'b0};
        end
        return pc + 32'd4;
    endfunction

    function automatic int md_latency(input instr_word_u w);
        if (w.r.opcode != op_op || w.r.funct7 != funct7_muldiv)
            return 0;
        if (w.r.funct3 == 3'd0)
            return mul_cycles;
        return (w.r.funct3 == 3'd4) ? div_cycles : 0;
    endfunction

    function automatic string step_name(input instr_word_u w);
        if (w.r.opcode == op_jal)
            return "commit after jal";
        if (w.r.opcode == op_jalr)
            return "commit after jalr";
        if (md_latency(w) != 0)
            return "commit after mul/div";
        return "straight-line commit";
    endfunction

    task automatic build_trace();
        logic [xlen-1:0] pc;
        pc = reset_pc;
        exp_pc_q.delete();
        for (int k = 0; k < trace_len; k++) begin
            exp_pc_q.push_back(pc);
            pc = ref_next_pc(pc, mem_word(pc));
        end
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_pc(input string test, input logic [xlen-1:0] exp,
                            input logic [xlen-1:0] act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", test, exp, act));
    endtask

    task automatic check_instr(input string test, input instr_word_u exp,
                               input instr_word_u act);
        if (act !== exp)
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", test, exp, act));
    endtask

    task automatic check_count(input string test, input int exp, input int act);
        if (act != exp)
            abort_run($sformatf("CHECK FAILED %s expected %0d actual %0d", test, exp, act));
    endtask

`endif

//--- tb_fetch_frontend.sv
`timescale 1ns/10ps

module tb_fetch_frontend
    import cpu_pkg::*;
    import bus_pkg::*;
();

    localparam int trace_len = 40;
    localparam int timeout_cycles = 40 * trace_len;
    localparam int reset_cycles = 8;

    logic              clk;
    logic              rst_n;
    logic              hold;
    logic              ar_ready;
    logic              r_valid;
    logic [data_w-1:0] r_data;
    logic              ar_valid;
    logic [addr_w-1:0] ar_addr;
    logic              commit_valid;
    logic [xlen-1:0]   commit_pc;
    logic [xlen-1:0]   commit_instr;
    logic              md_busy;

    logic [xlen-1:0]   prog_words [logic [xlen-1:0]];
    logic [xlen-1:0]   exp_pc_q [$];
    int                commit_idx;
    int                fail_count;
    int                cycle_cnt;
    int                busy_run;
    int                busy_expect;
    logic              ar_valid_prev;

    fetch_frontend_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .hold         (hold),
        .ar_ready     (ar_ready),
        .r_valid      (r_valid),
        .r_data       (r_data),
        .ar_valid     (ar_valid),
        .ar_addr      (ar_addr),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_instr (commit_instr),
        .md_busy      (md_busy)
    );

    task automatic abort_run(input string reason);
        fail_count++;
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    `include "tb_program.svh"

    always #20 clk = ~clk;

    // ========================================================================
    // Memory model with random ready delay and read latency
    // ========================================================================
    initial begin : memory_model
        logic [addr_w-1:0] addr;
        int unsigned       ready_wait;
        int unsigned       latency;
        bit                first_read;
        first_read = 1'b1;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #2;
            if (ar_valid) begin
                addr = ar_addr;
                if (first_read)
                    check_pc("first fetch address", reset_pc, addr);
                first_read = 1'b0;
                ready_wait = $urandom_range(ready_delay_max, 0);
                repeat (ready_wait) begin
                    @(posedge clk);
                    #2;
                    if (!ar_valid)
                        abort_run("ar_valid dropped before the address handshake");
                    check_pc("address held while waiting", addr, ar_addr);
                end
                ar_ready = 1'b1;
                @(posedge clk);
                #2;
                ar_ready = 1'b0;
                latency = $urandom_range(r_latency_max, r_latency_min);
                repeat (latency - 1) begin
                    @(posedge clk);
                    #2;
                end
                r_valid = 1'b1;
                r_data = mem_word(addr);
                @(posedge clk);
                #2;
                r_valid = 1'b0;
                r_data = '0;
            end
        end
    end

    initial begin : drive_hold
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #2;
            hold = ($urandom_range(3, 0) == 0);     // Stall about one cycle in four
        end
    end

    // ========================================================================
    // Monitors
    // ========================================================================
    always @(negedge clk) begin : compare_commits
        logic [xlen-1:0] pc_exp;
        string           test;
        if (rst_n && commit_valid && commit_idx < trace_len) begin
            pc_exp = exp_pc_q[commit_idx];
            if (commit_idx == 0)
                test = "first commit after reset";
            else
                test = step_name(mem_word(exp_pc_q[commit_idx - 1]));
            check_pc(test, pc_exp, commit_pc);
            check_instr(test, mem_word(pc_exp), commit_instr);
            if (md_latency(mem_word(pc_exp)) != 0)
                busy_expect = md_latency(mem_word(pc_exp));
            commit_idx++;
        end
    end

    always @(negedge clk) begin : watch_md_busy
        if (!rst_n && (ar_valid !== 1'b0 || commit_valid !== 1'b0))
            abort_run("ar_valid or commit_valid was not low during reset");
        if (rst_n) begin
            if (md_busy && ar_valid && !ar_valid_prev)
                abort_run("ar_valid rose while the mul/div unit was busy");
            if (md_busy) begin
                busy_run++;
            end else if (busy_run != 0) begin
                check_count("mul/div busy cycles", busy_expect, busy_run);
                busy_run = 0;
                busy_expect = 0;
            end
            ar_valid_prev = ar_valid;
        end
    end

    always @(posedge clk) begin : watchdog
        if (rst_n) begin
            cycle_cnt++;
            if (cycle_cnt > timeout_cycles)
                abort_run($sformatf("Timeout after %0d cycles with %0d of %0d commits seen",
                                    cycle_cnt, commit_idx, trace_len));
        end
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin : main_flow
        clk = 1'b0;
        rst_n = 1'b0;
        hold = 1'b0;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_data = '0;
        commit_idx = 0;
        fail_count = 0;
        cycle_cnt = 0;
        busy_run = 0;
        busy_expect = 0;
        ar_valid_prev = 1'b0;
        void'($urandom(29179));
        build_program();
        build_trace();
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst_n = 1'b1;
        wait (commit_idx == trace_len);
        repeat (2) @(posedge clk);
        if (fail_count == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "Commit sequence mismatch");
        end
    end

endmodule

//--- build.f
+incdir+.
cpu_pkg.sv
bus_pkg.sv
pc_gen.sv
fetch_port.sv
instr_decode.sv
md_latency_timer.sv
fetch_frontend_top.sv
tb_fetch_frontend.sv

//--- run.sh
#!/bin/sh
# Build and run the fetch front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_fetch_frontend -o tb_fetch_frontend
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_frontend > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if grep -q "Testbench failed" "$log"; then
    echo "FAIL"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    exit 1
fi
echo "PASS"
exit 0
